// File: build.f
source/sfu_pkg.sv
source/sfu_decode.sv
source/wctl_unit.sv
source/csr_unit.sv
source/sfu_result_arb.sv
source/sfu_unit.sv
dv/sfu_unit_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= sfu_unit_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -x "Everything OK" > /dev/null

clean:
	rm -rf $(OBJ_DIR)

// File: dv/sfu_unit_tb.sv
// Directed testbench for the scalar SFU
// Checks commits and warp-control pulses against a reference model of the CSRs
`timescale 1ns/1ps

module sfu_unit_tb import sfu_pkg::*; ();

    localparam int STREAM_LEN     = 24;
    localparam int OP_BUDGET      = 10;
    // Reset, 35 directed ops, then the stalled stream
    localparam int TIMEOUT_CYCLES = 4 + OP_BUDGET * 35 + 16 * STREAM_LEN + 200;

    logic                  clk;
    logic                  reset;
    logic                  dispatch_valid;
    logic                  dispatch_ready;
    logic [WID_W-1:0]      dispatch_wid;
    logic [THREAD_CNT-1:0] dispatch_tmask;
    logic [OP_W-1:0]       dispatch_op;
    logic [XLEN-1:0]       dispatch_rs1;
    sfu_arg_t              dispatch_arg;
    logic [NR_BITS-1:0]    dispatch_rd;
    logic                  dispatch_wb;
    logic                  commit_valid;
    logic                  commit_ready;
    logic [WID_W-1:0]      commit_wid;
    logic [THREAD_CNT-1:0] commit_tmask;
    logic [NR_BITS-1:0]    commit_rd;
    logic                  commit_wb;
    logic [XLEN-1:0]       commit_data;
    logic                  warp_ctl_valid;
    logic [WID_W-1:0]      warp_ctl_wid;
    logic [OP_W-1:0]       warp_ctl_op;
    logic [XLEN-1:0]       warp_ctl_value;

    integer             seed;
    int                 errors;
    int                 n_commits;
    int                 stall_seen;
    string              test_name;
    logic [NR_BITS-1:0] rd_next;
    logic [XLEN-1:0]    scr_model [NUM_SCRATCH];
    // Expected commit {unit, wid, tmask, rd, wb, data}, unit is 1 for CSR
    logic [44:0]        exp_q [$];
    // Expected warp-control pulse {op, wid, value}
    logic [37:0]        pulse_q [$];

    sfu_unit uut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_CYCLES * 100);
        $display("Timeout: run went past %0d cycles in test %s", TIMEOUT_CYCLES, test_name);
        $display("Something failed");
        $finish;
    end

    function automatic logic [XLEN-1:0] next_random();
        return $random(seed);
    endfunction

    function automatic sfu_arg_t csr_arg(input logic [CSR_ADDR_W-1:0] addr);
        return sfu_arg_t'({4'h0, addr});
    endfunction

    function automatic logic [OP_W-1:0] pick_op(input int kind);
        case (kind)
            0:       return SFU_TMC;
            1:       return SFU_WSPAWN;
            2:       return SFU_BAR;
            3:       return SFU_CSRRW;
            4:       return SFU_CSRRS;
            default: return SFU_CSRRC;
        endcase
    endfunction

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_ADDR_W-1:0] addr,
            input logic [WID_W-1:0] wid, input logic [THREAD_CNT-1:0] tmask);
        logic [XLEN-1:0] val;
        val = '0;
        if (addr >= CSR_SCRATCH0 && addr <= CSR_SCRATCH3) begin
            val = scr_model[addr[1:0]];
        end else if (addr == CSR_WARP_ID) begin
            val = XLEN'(wid);
        end else if (addr == CSR_TMASK) begin
            val = XLEN'(tmask);
        end else if (addr == CSR_NUM_WARPS) begin
            val = XLEN'(WARP_CNT);
        end else if (addr == CSR_RETIRED) begin
            val = XLEN'(n_commits);
        end
        return val;
    endfunction

    // Commits of the two units may interleave, so match on rd
    function automatic void match_commit();
        int          idx;
        logic [44:0] act;
        idx = -1;
        act = {1'b0, commit_wid, commit_tmask, commit_rd, commit_wb, commit_data};
        for (int i = 0; i < exp_q.size(); i++) begin
            if (idx < 0 && exp_q[i][37:33] == commit_rd) begin
                idx = i;
            end
        end
        if (idx < 0) begin
            errors++;
            $display("Unexpected commit for rd %0d in test %s", commit_rd, test_name);
        end else begin
            for (int i = 0; i < idx; i++) begin
                if (exp_q[i][44] == exp_q[idx][44]) begin
                    errors++;
                    $display("Commit for rd %0d overtook an older one of its unit", commit_rd);
                end
            end
            if (exp_q[idx][43:0] != act[43:0]) begin
                errors++;
                $display("Fail %s: expected %h, actual %h", test_name, exp_q[idx][43:0],
                         act[43:0]);
            end
            exp_q.delete(idx);
        end
    endfunction

    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            match_commit();
            n_commits++;
        end
        if (!reset && warp_ctl_valid) begin
            if (pulse_q.size() == 0) begin
                errors++;
                $display("Unexpected warp-control pulse in test %s", test_name);
            end else begin
                if ({warp_ctl_op, warp_ctl_wid, warp_ctl_value} != pulse_q[0]) begin
                    errors++;
                    $display("Fail %s: expected %h, actual %h", test_name, pulse_q[0],
                             {warp_ctl_op, warp_ctl_wid, warp_ctl_value});
                end
                void'(pulse_q.pop_front());
            end
        end
        if (dispatch_valid && !dispatch_ready) begin
            stall_seen++;
        end
    end

    task automatic issue(input logic [OP_W-1:0] op, input logic [XLEN-1:0] rs1,
            input sfu_arg_t arg);
        logic [XLEN-1:0]       rnd;
        logic [XLEN-1:0]       old_val;
        logic [XLEN-1:0]       value;
        logic [CSR_ADDR_W-1:0] addr;
        rnd  = next_random();
        addr = arg.csr.addr;
        if (op == SFU_CSRRW || op == SFU_CSRRS || op == SFU_CSRRC) begin
            old_val = model_read(addr, rnd[1:0], rnd[5:2]);
            exp_q.push_back({1'b1, rnd[1:0], rnd[5:2], rd_next, rnd[6], old_val});
            if (addr >= CSR_SCRATCH0 && addr <= CSR_SCRATCH3) begin
                case (op)
                    SFU_CSRRS: scr_model[addr[1:0]] = old_val | rs1;
                    SFU_CSRRC: scr_model[addr[1:0]] = old_val & ~rs1;
                    default:   scr_model[addr[1:0]] = rs1;
                endcase
            end
        end else begin
            case (op)
                SFU_TMC:    value = XLEN'(rs1[THREAD_CNT-1:0]);
                SFU_WSPAWN: value = rs1;
                default:    value = XLEN'({arg.wctl.bar_cnt, arg.wctl.bar_id});
            endcase
            // Warp control commits with no writeback even when wb is asked for
            exp_q.push_back({1'b0, rnd[1:0], rnd[5:2], rd_next, 1'b0, {XLEN{1'b0}}});
            pulse_q.push_back({op, rnd[1:0], value});
        end
        dispatch_valid = 1'b1;
        dispatch_wid   = rnd[1:0];
        dispatch_tmask = rnd[5:2];
        dispatch_op    = op;
        dispatch_rs1   = rs1;
        dispatch_arg   = arg;
        dispatch_rd    = rd_next;
        dispatch_wb    = rnd[6];
        rd_next        = rd_next + 5'd1;
        do begin
            @(posedge clk);
        end while (!dispatch_ready);
        #10;
        dispatch_valid = 1'b0;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 100) begin
            @(posedge clk);
            #10;
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("Commits still missing at the end of test %s", test_name);
        end
        if (pulse_q.size() != 0) begin
            errors++;
            $display("Warp-control pulses still missing at the end of test %s", test_name);
        end
    endtask

    task automatic check_reset_and_latency();
        int lat;
        test_name = "reset";
        if (dispatch_ready !== 1'b1 || commit_valid !== 1'b0 || warp_ctl_valid !== 1'b0) begin
            errors++;
            $display("Outputs are not idle after reset");
        end
        test_name = "latency";
        issue(SFU_CSRRW, next_random(), csr_arg(CSR_SCRATCH0));
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!commit_valid && lat < 10);
        #10;
        if (lat != 3) begin
            errors++;
            $display("Fail %s: expected 3, actual %0d", test_name, lat);
        end
        drain();
    endtask

    task automatic test_scratch();
        test_name = "scratch";
        for (int i = 0; i < NUM_SCRATCH; i++) begin
            issue(SFU_CSRRW, next_random(), csr_arg(CSR_SCRATCH0 + CSR_ADDR_W'(i)));
            issue(SFU_CSRRS, next_random(), csr_arg(CSR_SCRATCH0 + CSR_ADDR_W'(i)));
            issue(SFU_CSRRC, next_random(), csr_arg(CSR_SCRATCH0 + CSR_ADDR_W'(i)));
        end
        // Final reads
        for (int i = 0; i < NUM_SCRATCH; i++) begin
            issue(SFU_CSRRS, '0, csr_arg(CSR_SCRATCH0 + CSR_ADDR_W'(i)));
        end
        drain();
    endtask

    task automatic test_status();
        logic [CSR_ADDR_W-1:0] addrs [5];
        addrs = '{CSR_WARP_ID, CSR_TMASK, CSR_NUM_WARPS, CSR_RETIRED, 12'h123};
        test_name = "status";
        foreach (addrs[i]) begin
            issue(SFU_CSRRS, '0, csr_arg(addrs[i]));
            drain();
            issue(SFU_CSRRW, next_random(), csr_arg(addrs[i]));
            drain();
            issue(SFU_CSRRS, '0, csr_arg(addrs[i]));
            drain();
        end
    endtask

    task automatic test_warp_ctl();
        test_name = "warp_ctl";
        issue(SFU_TMC, next_random(), '0);
        drain();
        issue(SFU_WSPAWN, next_random(), '0);
        drain();
        issue(SFU_BAR, next_random(), sfu_arg_t'({8'h00, 4'd3, 4'd9}));
        drain();
    endtask

    task automatic test_backpressure();
        logic [3:0]      stall_word [STREAM_LEN];
        logic [XLEN-1:0] r;
        int              kind;
        logic [OP_W-1:0] op;
        test_name  = "backpressure";
        stall_seen = 0;
        // Stall pattern, one word per stretch of commit_ready
        for (int i = 0; i < STREAM_LEN; i++) begin
            r = next_random();
            stall_word[i] = r[3:0];
        end
        fork
            begin
                for (int i = 0; i < STREAM_LEN; i++) begin
                    r    = next_random();
                    kind = int'(r[23:20]) % 6;
                    op   = pick_op(kind);
                    if (kind >= 3) begin
                        issue(op, next_random(), csr_arg(CSR_SCRATCH0 | CSR_ADDR_W'(r[7:6])));
                    end else begin
                        issue(op, next_random(), sfu_arg_t'({8'h00, r[15:8]}));
                    end
                end
            end
            begin
                for (int j = 0; j < STREAM_LEN; j++) begin
                    commit_ready = stall_word[j][3];
                    repeat (int'(stall_word[j][2:0]) + 1) @(posedge clk);
                    #10;
                end
                commit_ready = 1'b1;
            end
        join
        drain();
        if (stall_seen == 0) begin
            errors++;
            $display("Dispatch never stalled while commits were held back");
        end
    endtask

    initial begin
        seed           = 32'hecb5;
        errors         = 0;
        n_commits      = 0;
        stall_seen     = 0;
        rd_next        = '0;
        test_name      = "reset";
        scr_model      = '{default: '0};
        reset          = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_wid   = '0;
        dispatch_tmask = '0;
        dispatch_op    = '0;
        dispatch_rs1   = '0;
        dispatch_arg   = '0;
        dispatch_rd    = '0;
        dispatch_wb    = 1'b0;
        commit_ready   = 1'b1;
        repeat (4) @(posedge clk);
        #10;
        reset = 1'b0;

        check_reset_and_latency();
        test_scratch();
        test_status();
        test_warp_ctl();
        test_backpressure();

        $display("Checks finished with %0d errors over %0d commits", errors, n_commits);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// File: source/sfu_unit.sv
// Scalar SFU top: dispatch register, warp-control and CSR units, commit arbiter
// Three-stage pipe from dispatch to commit
`timescale 1ns/1ps

module sfu_unit import sfu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  dispatch_valid,
    output logic                  dispatch_ready,
    input  logic [WID_W-1:0]      dispatch_wid,
    input  logic [THREAD_CNT-1:0] dispatch_tmask,
    input  logic [OP_W-1:0]       dispatch_op,
    input  logic [XLEN-1:0]       dispatch_rs1,
    input  sfu_arg_t              dispatch_arg,
    input  logic [NR_BITS-1:0]    dispatch_rd,
    input  logic                  dispatch_wb,

    output logic                  commit_valid,
    input  logic                  commit_ready,
    output logic [WID_W-1:0]      commit_wid,
    output logic [THREAD_CNT-1:0] commit_tmask,
    output logic [NR_BITS-1:0]    commit_rd,
    output logic                  commit_wb,
    output logic [XLEN-1:0]       commit_data,

    output logic                  warp_ctl_valid,
    output logic [WID_W-1:0]      warp_ctl_wid,
    output logic [OP_W-1:0]       warp_ctl_op,
    output logic [XLEN-1:0]       warp_ctl_value
);

    // Shared execute bus
    logic [WID_W-1:0]      exe_wid;
    logic [THREAD_CNT-1:0] exe_tmask;
    logic [OP_W-1:0]       exe_op;
    logic [XLEN-1:0]       exe_rs1;
    sfu_arg_t              exe_arg;
    logic [NR_BITS-1:0]    exe_rd;
    logic                  exe_wb;
    logic                  wctl_valid;
    logic                  wctl_ready;
    logic                  csr_valid;
    logic                  csr_ready;

    // Responses into the arbiter
    logic                  wctl_rsp_valid;
    logic                  wctl_rsp_ready;
    logic [WID_W-1:0]      wctl_rsp_wid;
    logic [THREAD_CNT-1:0] wctl_rsp_tmask;
    logic [NR_BITS-1:0]    wctl_rsp_rd;
    logic                  wctl_rsp_wb;
    logic [XLEN-1:0]       wctl_rsp_data;
    logic                  csr_rsp_valid;
    logic                  csr_rsp_ready;
    logic [WID_W-1:0]      csr_rsp_wid;
    logic [THREAD_CNT-1:0] csr_rsp_tmask;
    logic [NR_BITS-1:0]    csr_rsp_rd;
    logic                  csr_rsp_wb;
    logic [XLEN-1:0]       csr_rsp_data;
    logic                  retire;

    sfu_decode decode (
        .clk            (clk),
        .reset          (reset),
        .dispatch_valid (dispatch_valid),
        .dispatch_ready (dispatch_ready),
        .dispatch_wid   (dispatch_wid),
        .dispatch_tmask (dispatch_tmask),
        .dispatch_op    (dispatch_op),
        .dispatch_rs1   (dispatch_rs1),
        .dispatch_arg   (dispatch_arg),
        .dispatch_rd    (dispatch_rd),
        .dispatch_wb    (dispatch_wb),
        .exe_wid        (exe_wid),
        .exe_tmask      (exe_tmask),
        .exe_op         (exe_op),
        .exe_rs1        (exe_rs1),
        .exe_arg        (exe_arg),
        .exe_rd         (exe_rd),
        .exe_wb         (exe_wb),
        .wctl_valid     (wctl_valid),
        .wctl_ready     (wctl_ready),
        .csr_valid      (csr_valid),
        .csr_ready      (csr_ready)
    );

    wctl_unit wctl (
        .clk            (clk),
        .reset          (reset),
        .exe_wid        (exe_wid),
        .exe_tmask      (exe_tmask),
        .exe_op         (exe_op),
        .exe_rs1        (exe_rs1),
        .exe_arg        (exe_arg),
        .exe_rd         (exe_rd),
        .wctl_valid     (wctl_valid),
        .wctl_ready     (wctl_ready),
        .warp_ctl_valid (warp_ctl_valid),
        .warp_ctl_wid   (warp_ctl_wid),
        .warp_ctl_op    (warp_ctl_op),
        .warp_ctl_value (warp_ctl_value),
        .rsp_valid      (wctl_rsp_valid),
        .rsp_ready      (wctl_rsp_ready),
        .rsp_wid        (wctl_rsp_wid),
        .rsp_tmask      (wctl_rsp_tmask),
        .rsp_rd         (wctl_rsp_rd),
        .rsp_wb         (wctl_rsp_wb),
        .rsp_data       (wctl_rsp_data)
    );

    csr_unit csr (
        .clk            (clk),
        .reset          (reset),
        .exe_wid        (exe_wid),
        .exe_tmask      (exe_tmask),
        .exe_op         (exe_op),
        .exe_rs1        (exe_rs1),
        .exe_arg        (exe_arg),
        .exe_rd         (exe_rd),
        .exe_wb         (exe_wb),
        .csr_valid      (csr_valid),
        .csr_ready      (csr_ready),
        .retire         (retire),
        .rsp_valid      (csr_rsp_valid),
        .rsp_ready      (csr_rsp_ready),
        .rsp_wid        (csr_rsp_wid),
        .rsp_tmask      (csr_rsp_tmask),
        .rsp_rd         (csr_rsp_rd),
        .rsp_wb         (csr_rsp_wb),
        .rsp_data       (csr_rsp_data)
    );

    sfu_result_arb result (
        .clk            (clk),
        .reset          (reset),
        .wctl_rsp_valid (wctl_rsp_valid),
        .wctl_rsp_ready (wctl_rsp_ready),
        .wctl_rsp_wid   (wctl_rsp_wid),
        .wctl_rsp_tmask (wctl_rsp_tmask),
        .wctl_rsp_rd    (wctl_rsp_rd),
        .wctl_rsp_wb    (wctl_rsp_wb),
        .wctl_rsp_data  (wctl_rsp_data),
        .csr_rsp_valid  (csr_rsp_valid),
        .csr_rsp_ready  (csr_rsp_ready),
        .csr_rsp_wid    (csr_rsp_wid),
        .csr_rsp_tmask  (csr_rsp_tmask),
        .csr_rsp_rd     (csr_rsp_rd),
        .csr_rsp_wb     (csr_rsp_wb),
        .csr_rsp_data   (csr_rsp_data),
        .commit_valid   (commit_valid),
        .commit_ready   (commit_ready),
        .commit_wid     (commit_wid),
        .commit_tmask   (commit_tmask),
        .commit_rd      (commit_rd),
        .commit_wb      (commit_wb),
        .commit_data    (commit_data),
        .retire         (retire)
    );

endmodule

// File: source/sfu_result_arb.sv
// Round-robin merge of the warp-control and CSR responses
// Output register feeds the commit port; retire pulses per commit
`timescale 1ns/1ps

module sfu_result_arb import sfu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  wctl_rsp_valid,
    output logic                  wctl_rsp_ready,
    input  logic [WID_W-1:0]      wctl_rsp_wid,
    input  logic [THREAD_CNT-1:0] wctl_rsp_tmask,
    input  logic [NR_BITS-1:0]    wctl_rsp_rd,
    input  logic                  wctl_rsp_wb,
    input  logic [XLEN-1:0]       wctl_rsp_data,

    input  logic                  csr_rsp_valid,
    output logic                  csr_rsp_ready,
    input  logic [WID_W-1:0]      csr_rsp_wid,
    input  logic [THREAD_CNT-1:0] csr_rsp_tmask,
    input  logic [NR_BITS-1:0]    csr_rsp_rd,
    input  logic                  csr_rsp_wb,
    input  logic [XLEN-1:0]       csr_rsp_data,

    output logic                  commit_valid,
    input  logic                  commit_ready,
    output logic [WID_W-1:0]      commit_wid,
    output logic [THREAD_CNT-1:0] commit_tmask,
    output logic [NR_BITS-1:0]    commit_rd,
    output logic                  commit_wb,
    output logic [XLEN-1:0]       commit_data,

    output logic                  retire
);

    logic out_ready;
    logic prio_csr;
    logic grant_csr;
    logic take_wctl;
    logic take_csr;

    assign out_ready = !commit_valid || commit_ready;

    // Tie goes to whichever side was not served last
    assign grant_csr      = csr_rsp_valid && (!wctl_rsp_valid || prio_csr);
    assign wctl_rsp_ready = out_ready && !grant_csr;
    assign csr_rsp_ready  = out_ready && grant_csr;
    assign take_wctl      = wctl_rsp_valid && wctl_rsp_ready;
    assign take_csr       = csr_rsp_valid && csr_rsp_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            commit_valid <= 1'b0;
            prio_csr     <= 1'b0;
        end else begin
            if (out_ready) begin
                commit_valid <= take_wctl || take_csr;
            end
            if (take_wctl) begin
                prio_csr <= 1'b1;
            end else if (take_csr) begin
                prio_csr <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take_csr) begin
            commit_wid   <= csr_rsp_wid;
            commit_tmask <= csr_rsp_tmask;
            commit_rd    <= csr_rsp_rd;
            commit_wb    <= csr_rsp_wb;
            commit_data  <= csr_rsp_data;
        end else if (take_wctl) begin
            commit_wid   <= wctl_rsp_wid;
            commit_tmask <= wctl_rsp_tmask;
            commit_rd    <= wctl_rsp_rd;
            commit_wb    <= wctl_rsp_wb;
            commit_data  <= wctl_rsp_data;
        end
    end

    assign retire = commit_valid && commit_ready;

    assert property (@(posedge clk) disable iff (reset) !(take_wctl && take_csr));

endmodule

// File: source/csr_unit.sv
// CSR unit: scratch registers plus read-only status registers
// Executes CSRRW/CSRRS/CSRRC and returns the old value
`timescale 1ns/1ps

module csr_unit import sfu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [WID_W-1:0]      exe_wid,
    input  logic [THREAD_CNT-1:0] exe_tmask,
    input  logic [OP_W-1:0]       exe_op,
    input  logic [XLEN-1:0]       exe_rs1,
    input  sfu_arg_t              exe_arg,
    input  logic [NR_BITS-1:0]    exe_rd,
    input  logic                  exe_wb,
    input  logic                  csr_valid,
    output logic                  csr_ready,

    input  logic                  retire,

    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [WID_W-1:0]      rsp_wid,
    output logic [THREAD_CNT-1:0] rsp_tmask,
    output logic [NR_BITS-1:0]    rsp_rd,
    output logic                  rsp_wb,
    output logic [XLEN-1:0]       rsp_data
);

    logic [XLEN-1:0] scratch [NUM_SCRATCH];
    logic [XLEN-1:0] retired_cnt;
    logic [XLEN-1:0] old_val;
    logic [XLEN-1:0] new_val;
    logic [1:0]      idx;
    logic            is_scratch;
    logic            accept;

    assign csr_ready = !rsp_valid || rsp_ready;
    assign accept    = csr_valid && csr_ready;
    assign idx       = exe_arg.csr.addr[1:0];

    always_comb begin
        is_scratch = 1'b0;
        case (exe_arg.csr.addr)
            CSR_SCRATCH0, CSR_SCRATCH1, CSR_SCRATCH2, CSR_SCRATCH3: begin
                is_scratch = 1'b1;
                old_val    = scratch[idx];
            end
            CSR_WARP_ID:   old_val = XLEN'(exe_wid);
            CSR_TMASK:     old_val = XLEN'(exe_tmask);
            CSR_NUM_WARPS: old_val = XLEN'(WARP_CNT);
            CSR_RETIRED:   old_val = retired_cnt;
            default:       old_val = '0;
        endcase
    end

    always_comb begin
        case (exe_op)
            SFU_CSRRS: new_val = old_val | exe_rs1;
            SFU_CSRRC: new_val = old_val & ~exe_rs1;
            default:   new_val = exe_rs1;
        endcase
    end

    // Status registers and unmapped addresses drop the write
    always_ff @(posedge clk) begin
        if (reset) begin
            scratch <= '{default: '0};
        end else if (accept && is_scratch) begin
            scratch[idx] <= new_val;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            retired_cnt <= '0;
            rsp_valid   <= 1'b0;
        end else begin
            if (retire) begin
                retired_cnt <= retired_cnt + XLEN'(1);
            end
            if (csr_ready) begin
                rsp_valid <= csr_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rsp_wid   <= exe_wid;
            rsp_tmask <= exe_tmask;
            rsp_rd    <= exe_rd;
            rsp_wb    <= exe_wb;
            rsp_data  <= old_val;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp_data));

endmodule

// File: source/wctl_unit.sv
// Warp-control unit: tmc, wspawn and bar
// Emits a one-cycle warp-control request and a commit with no writeback
`timescale 1ns/1ps

module wctl_unit import sfu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic [WID_W-1:0]      exe_wid,
    input  logic [THREAD_CNT-1:0] exe_tmask,
    input  logic [OP_W-1:0]       exe_op,
    input  logic [XLEN-1:0]       exe_rs1,
    input  sfu_arg_t              exe_arg,
    input  logic [NR_BITS-1:0]    exe_rd,
    input  logic                  wctl_valid,
    output logic                  wctl_ready,

    output logic                  warp_ctl_valid,
    output logic [WID_W-1:0]      warp_ctl_wid,
    output logic [OP_W-1:0]       warp_ctl_op,
    output logic [XLEN-1:0]       warp_ctl_value,

    output logic                  rsp_valid,
    input  logic                  rsp_ready,
    output logic [WID_W-1:0]      rsp_wid,
    output logic [THREAD_CNT-1:0] rsp_tmask,
    output logic [NR_BITS-1:0]    rsp_rd,
    output logic                  rsp_wb,
    output logic [XLEN-1:0]       rsp_data
);

    logic            accept;
    logic            known_op;
    logic [XLEN-1:0] ctl_value;

    assign wctl_ready = !rsp_valid || rsp_ready;
    assign accept     = wctl_valid && wctl_ready;

    always_comb begin
        known_op  = 1'b1;
        ctl_value = '0;
        case (exe_op)
            SFU_TMC:    ctl_value = XLEN'(exe_rs1[THREAD_CNT-1:0]);
            SFU_WSPAWN: ctl_value = exe_rs1;
            SFU_BAR:    ctl_value = XLEN'({exe_arg.wctl.bar_cnt, exe_arg.wctl.bar_id});
            default:    known_op  = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            warp_ctl_valid <= 1'b0;
            rsp_valid      <= 1'b0;
        end else begin
            warp_ctl_valid <= accept && known_op;
            if (wctl_ready) begin
                rsp_valid <= wctl_valid;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            warp_ctl_wid   <= exe_wid;
            warp_ctl_op    <= exe_op;
            warp_ctl_value <= ctl_value;
            rsp_wid        <= exe_wid;
            rsp_tmask      <= exe_tmask;
            rsp_rd         <= exe_rd;
        end
    end

    // Warp control never writes a register
    assign rsp_wb   = 1'b0;
    assign rsp_data = '0;

    assert property (@(posedge clk) disable iff (reset)
        warp_ctl_valid && !accept |=> !warp_ctl_valid);

endmodule

// File: source/sfu_decode.sv
// Dispatch register of the SFU
// Holds one instruction and steers it to the warp-control or CSR unit
`timescale 1ns/1ps

module sfu_decode import sfu_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  dispatch_valid,
    output logic                  dispatch_ready,
    input  logic [WID_W-1:0]      dispatch_wid,
    input  logic [THREAD_CNT-1:0] dispatch_tmask,
    input  logic [OP_W-1:0]       dispatch_op,
    input  logic [XLEN-1:0]       dispatch_rs1,
    input  sfu_arg_t              dispatch_arg,
    input  logic [NR_BITS-1:0]    dispatch_rd,
    input  logic                  dispatch_wb,

    output logic [WID_W-1:0]      exe_wid,
    output logic [THREAD_CNT-1:0] exe_tmask,
    output logic [OP_W-1:0]       exe_op,
    output logic [XLEN-1:0]       exe_rs1,
    output sfu_arg_t              exe_arg,
    output logic [NR_BITS-1:0]    exe_rd,
    output logic                  exe_wb,

    output logic                  wctl_valid,
    input  logic                  wctl_ready,
    output logic                  csr_valid,
    input  logic                  csr_ready
);

    logic exe_valid;
    logic is_csr;
    logic sel_ready;

    always_comb begin
        case (exe_op)
            SFU_CSRRW, SFU_CSRRS, SFU_CSRRC: is_csr = 1'b1;
            // Unknown codes fall through to warp control
            default: is_csr = 1'b0;
        endcase
    end

    assign wctl_valid     = exe_valid && !is_csr;
    assign csr_valid      = exe_valid && is_csr;
    assign sel_ready      = is_csr ? csr_ready : wctl_ready;
    assign dispatch_ready = !exe_valid || sel_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (dispatch_ready) begin
            exe_valid <= dispatch_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dispatch_valid && dispatch_ready) begin
            exe_wid   <= dispatch_wid;
            exe_tmask <= dispatch_tmask;
            exe_op    <= dispatch_op;
            exe_rs1   <= dispatch_rs1;
            exe_arg   <= dispatch_arg;
            exe_rd    <= dispatch_rd;
            exe_wb    <= dispatch_wb;
        end
    end

    // A stalled request must not change unit under the execute stage
    assert property (@(posedge clk) disable iff (reset)
        exe_valid && !sel_ready |=> exe_valid && $stable(exe_op));

endmodule

// File: source/sfu_pkg.sv
// Shared widths, operation codes and CSR map of the scalar SFU
// Imported by every SFU module
package sfu_pkg;

    localparam int WARP_CNT    = 4;
    localparam int WID_W       = 2;
    localparam int THREAD_CNT  = 4;
    localparam int XLEN        = 32;
    localparam int NR_BITS     = 5;
    localparam int OP_W        = 4;
    localparam int CSR_ADDR_W  = 12;
    localparam int NUM_SCRATCH = 4;

    // SFU operation codes
    localparam logic [OP_W-1:0] SFU_TMC    = 4'd0;
    localparam logic [OP_W-1:0] SFU_WSPAWN = 4'd1;
    localparam logic [OP_W-1:0] SFU_BAR    = 4'd2;
    localparam logic [OP_W-1:0] SFU_CSRRW  = 4'd4;
    localparam logic [OP_W-1:0] SFU_CSRRS  = 4'd5;
    localparam logic [OP_W-1:0] SFU_CSRRC  = 4'd6;

    // Scratch block is 4-aligned, low address bits pick the entry
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH0 = 12'h800;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH1 = 12'h801;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH2 = 12'h802;
    localparam logic [CSR_ADDR_W-1:0] CSR_SCRATCH3 = 12'h803;

    // Read-only status registers
    localparam logic [CSR_ADDR_W-1:0] CSR_WARP_ID   = 12'hcc0;
    localparam logic [CSR_ADDR_W-1:0] CSR_TMASK     = 12'hcc1;
    localparam logic [CSR_ADDR_W-1:0] CSR_NUM_WARPS = 12'hcc2;
    localparam logic [CSR_ADDR_W-1:0] CSR_RETIRED   = 12'hcc3;

    // Argument word, read as a CSR address or as barrier fields
    typedef union packed {
        struct packed {
            logic [3:0]            unused;
            logic [CSR_ADDR_W-1:0] addr;
        } csr;
        struct packed {
            logic [7:0] unused;
            logic [3:0] bar_cnt;
            logic [3:0] bar_id;
        } wctl;
    } sfu_arg_t;

endpackage
